// File: sim/rob_core_golden.txt
// pc dest wr_mem halt data, all hex, one instruction per line
// stores and the halt use r0 as destination
00001000 01 0 0 0000a001
00001004 02 0 0 0000a002
00001008 01 0 0 0000a003
0000100c 00 1 0 57000001
00001010 00 1 0 57000002
00001014 03 0 0 0000a006
00001018 03 0 0 0000a007
0000101c 00 0 0 0000a008
00001020 04 0 0 0000a009
00001024 00 1 0 5700000a
00001028 05 0 0 0000a00b
0000102c 05 0 0 0000a00c
00001030 06 0 0 0000a00d
00001034 00 1 0 5700000e
00001038 00 1 0 5700000f
0000103c 07 0 0 0000a010
00001040 01 0 0 0000a011
00001044 02 0 0 0000a012
00001048 1f 0 0 0000a013
0000104c 1f 0 0 0000a014
00001050 00 1 0 57000015
00001054 08 0 0 0000a016
00001058 09 0 0 0000a017
0000105c 00 0 1 0000a018

// File: filelist.f
hw/rob_pkg.sv
hw/free_list.sv
hw/rename_map.sv
hw/rob.sv
hw/rob_core_top.sv
sim/rob_core_chk.sv
sim/rob_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rob core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module rob_core_tb \
    -Mdir obj_dir \
    -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vrob_core_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0

// File: sim/rob_core_tb.sv
// rob core testbench
// replays the golden program through dispatch, completion and stalls, checks retirement
`timescale 1ns/1ps

module rob_core_tb;
    import rob_pkg::*;

    localparam int NUM_INSTR      = 24;
    localparam int TIMEOUT_CYCLES = 2000;

    logic                      clock;
    logic                      reset;
    decoded_packet_t [N-1:0]   disp_packets;
    width_cnt_t                disp_count;
    width_cnt_t                disp_accept;
    phys_reg_idx_t   [N-1:0]   disp_t;
    cdb_packet_t     [N-1:0]   cdb;
    logic                      dm_stalled;
    rob_packet_t     [N-1:0]   retiring;
    width_cnt_t                num_retired;
    logic                      start_store;

    // golden program, five words per instruction
    logic [31:0]     golden_mem [0:5*NUM_INSTR-1];
    pc_t             g_pc       [NUM_INSTR];
    arch_reg_idx_t   g_dest     [NUM_INSTR];
    logic            g_wr_mem   [NUM_INSTR];
    logic            g_halt     [NUM_INSTR];
    data_t           g_data     [NUM_INSTR];

    // reference model state
    phys_reg_idx_t   free_q[$];
    phys_reg_idx_t   model_map  [ARCH_REGS];
    phys_reg_idx_t   exp_t      [NUM_INSTR];
    phys_reg_idx_t   exp_t_old  [NUM_INSTR];
    phys_reg_idx_t   comp_tag[$];
    data_t           comp_data[$];
    int              comp_due[$];

    integer seed;
    int     cyc;
    int     disp_ptr;
    int     ret_ptr;
    int     fill_ptr;
    logic   halt_seen;

    rob_core_top dut (
        .clock        (clock),
        .reset        (reset),
        .disp_packets (disp_packets),
        .disp_count   (disp_count),
        .disp_accept  (disp_accept),
        .disp_t       (disp_t),
        .cdb          (cdb),
        .dm_stalled   (dm_stalled),
        .retiring     (retiring),
        .num_retired  (num_retired),
        .start_store  (start_store)
    );

    bind rob rob_core_chk u_chk (
        .clock         (clock),
        .reset         (reset),
        .retiring_data (retiring_data),
        .num_retired   (num_retired),
        .start_store   (start_store)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_tag(input string name, input phys_reg_idx_t got,
                             input phys_reg_idx_t exp);
        if (got !== exp) fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_reg(input string name, input arch_reg_idx_t got,
                             input arch_reg_idx_t exp);
        if (got !== exp) fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input width_cnt_t got,
                               input width_cnt_t exp);
        if (got !== exp) fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic load_golden();
        $readmemh("sim/rob_core_golden.txt", golden_mem);
        for (int i = 0; i < NUM_INSTR; i++) begin
            g_pc[i]     = golden_mem[5*i];
            g_dest[i]   = arch_reg_idx_t'(golden_mem[5*i+1]);
            g_wr_mem[i] = golden_mem[5*i+2][0];
            g_halt[i]   = golden_mem[5*i+3][0];
            g_data[i]   = golden_mem[5*i+4];
        end
        if (!g_halt[NUM_INSTR-1]) fail_now("golden program does not end in a halt");
    endtask

    // random slice of the pending program, re-presented until accepted
    task automatic drive_dispatch();
        int want;
        want = {$random(seed)} % (N + 1);
        if (want > NUM_INSTR - disp_ptr) want = NUM_INSTR - disp_ptr;
        disp_packets = '0;
        for (int j = 0; j < N; j++) begin
            if (j < want) begin
                disp_packets[j].pc           = g_pc[disp_ptr+j];
                disp_packets[j].dest_reg_idx = g_dest[disp_ptr+j];
                disp_packets[j].halt         = g_halt[disp_ptr+j];
                disp_packets[j].wr_mem       = g_wr_mem[disp_ptr+j];
            end
        end
        disp_count = width_cnt_t'(want);
    endtask

    // up to N due completions, oldest scheduled first
    task automatic drive_cdb();
        int i;
        int n;
        cdb = '0;
        i   = 0;
        n   = 0;
        while (i < comp_tag.size()) begin
            if (n < N && comp_due[i] <= cyc) begin
                cdb[n].valid = 1'b1;
                cdb[n].t     = comp_tag[i];
                cdb[n].data  = comp_data[i];
                comp_tag.delete(i);
                comp_data.delete(i);
                comp_due.delete(i);
                n++;
            end else begin
                i++;
            end
        end
    endtask

    task automatic check_dispatch();
        phys_reg_idx_t tag;
        arch_reg_idx_t d;
        if (disp_accept > disp_count)
            fail_now($sformatf("[FAIL] disp_accept %h above disp_count %h",
                               disp_accept, disp_count));
        for (int j = 0; j < N; j++) begin
            if (j < int'(disp_accept)) begin
                if (free_q.size() == 0) fail_now("tag handed out while no tag was free");
                check_tag("disp_t", disp_t[j], free_q[0]);
                tag = free_q.pop_front();
                d   = g_dest[disp_ptr];
                exp_t[disp_ptr] = tag;
                // r0 frees its own tag, others free the previous mapping
                if (d == '0) begin
                    exp_t_old[disp_ptr] = tag;
                end else begin
                    exp_t_old[disp_ptr] = model_map[d];
                    model_map[d]        = tag;
                end
                comp_tag.push_back(tag);
                comp_data.push_back(g_data[disp_ptr]);
                comp_due.push_back(cyc + 1 + int'({$random(seed)} % 6));
                disp_ptr++;
            end
        end
    endtask

    task automatic check_retire();
        int stores;
        stores = 0;
        if (int'(num_retired) > N) fail_now("num_retired above the retire width");
        for (int i = 0; i < N; i++) begin
            if (i < int'(num_retired)) begin
                if (halt_seen) fail_now("an entry retired after the halt");
                if (ret_ptr >= disp_ptr) fail_now("an entry retired that was never dispatched");
                check_pc("retiring.pc", retiring[i].pc, g_pc[ret_ptr]);
                check_reg("retiring.dest_reg_idx", retiring[i].dest_reg_idx, g_dest[ret_ptr]);
                check_data("retiring.data", retiring[i].data, g_data[ret_ptr]);
                check_tag("retiring.t", retiring[i].t, exp_t[ret_ptr]);
                check_tag("retiring.t_old", retiring[i].t_old, exp_t_old[ret_ptr]);
                if (retiring[i].halt !== (ret_ptr == NUM_INSTR - 1))
                    fail_now("halt flag on a retiring entry does not match its place");
                if (retiring[i].wr_mem !== g_wr_mem[ret_ptr])
                    fail_now("store flag on a retiring entry does not match the program");
                if (g_wr_mem[ret_ptr]) stores++;
                if (g_halt[ret_ptr]) halt_seen = 1'b1;
                // freed tag joins the back of the free queue
                free_q.push_back(exp_t_old[ret_ptr]);
                ret_ptr++;
            end
        end
        if (stores > 1) fail_now("more than one store retired in one cycle");
        if (stores > 0 && dm_stalled) fail_now("a store retired while data memory stalled");
        if (start_store !== (stores > 0))
            fail_now($sformatf("[FAIL] start_store got %h expected %h",
                               start_store, stores > 0));
    endtask

    // younger work behind the halt, golden entries without the halt
    task automatic drive_filler();
        int k;
        for (int j = 0; j < N; j++) begin
            k = (fill_ptr + j) % (NUM_INSTR - 1);
            disp_packets[j].pc           = g_pc[k];
            disp_packets[j].dest_reg_idx = g_dest[k];
            disp_packets[j].halt         = 1'b0;
            disp_packets[j].wr_mem       = g_wr_mem[k];
        end
        disp_count = width_cnt_t'(N);
    endtask

    // accepted filler takes the next model tag and gets a completion
    task automatic accept_filler();
        phys_reg_idx_t tag;
        for (int j = 0; j < N; j++) begin
            if (j < int'(disp_accept)) begin
                if (free_q.size() == 0) fail_now("tag handed out while no tag was free");
                tag = free_q.pop_front();
                check_tag("disp_t", disp_t[j], tag);
                comp_tag.push_back(tag);
                comp_data.push_back(g_data[fill_ptr % (NUM_INSTR - 1)]);
                comp_due.push_back(cyc + 1 + int'({$random(seed)} % 6));
                fill_ptr++;
            end
        end
    endtask

    initial begin
        reset        = 1'b1;
        disp_packets = '0;
        disp_count   = '0;
        cdb          = '0;
        dm_stalled   = 1'b0;
        seed         = 32'h77d2_73db;
        cyc          = 0;
        disp_ptr     = 0;
        ret_ptr      = 0;
        fill_ptr     = 0;
        halt_seen    = 1'b0;
        for (int r = 0; r < ARCH_REGS; r++) model_map[r] = phys_reg_idx_t'(r);
        for (int k = ARCH_REGS; k < PHYS_REGS; k++) free_q.push_back(phys_reg_idx_t'(k));
        load_golden();

        repeat (4) @(posedge clock);
        #1 reset = 1'b0;

        // drive at +1, sample at +2 of every cycle
        while (!halt_seen) begin
            if (cyc >= TIMEOUT_CYCLES) fail_now("timeout waiting for the halt to retire");
            drive_dispatch();
            drive_cdb();
            dm_stalled = ({$random(seed)} % 4 == 0);
            #1;
            check_dispatch();
            check_retire();
            @(posedge clock);
            #1;
            cyc++;
        end

        if (ret_ptr != NUM_INSTR) fail_now("halt retired before the whole program");

        // rob must stay quiet after the halt, even with completed work behind it
        for (int c = 0; c < 20; c++) begin
            drive_filler();
            drive_cdb();
            dm_stalled = ({$random(seed)} % 4 == 0);
            #1;
            accept_filler();
            check_count("num_retired", num_retired, '0);
            if (start_store !== 1'b0) fail_now("start_store raised after the halt");
            @(posedge clock);
            #1;
            cyc++;
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: sim/rob_core_chk.sv
// retirement checker bound into the rob
// width, slot validity and reset behaviour of the retire outputs
`timescale 1ns/1ps

module rob_core_chk (
    input logic                                  clock,
    input logic                                  reset,
    input rob_pkg::rob_packet_t [rob_pkg::N-1:0] retiring_data,
    input rob_pkg::width_cnt_t                   num_retired,
    input logic                                  start_store
);
    import rob_pkg::*;

    // never more than the retire width
    a_retire_width: assert property (@(posedge clock) disable iff (reset)
        int'(num_retired) <= N)
        else $error("num_retired above retire width");

    // every slot handed out must be a finished entry
    for (genvar i = 0; i < N; i++) begin : g_slot
        a_slot_done: assert property (@(posedge clock) disable iff (reset)
            (int'(num_retired) > i) |-> (retiring_data[i].valid && retiring_data[i].complete))
            else $error("retiring slot not valid and complete");
    end

    // a store pulse needs something retiring
    a_store_with_retire: assert property (@(posedge clock) disable iff (reset)
        start_store |-> (num_retired != '0))
        else $error("start_store without retirement");

    // quiet once reset has been seen for a full edge
    a_reset_quiet: assert property (@(posedge clock)
        (reset && $past(reset)) |-> (num_retired == '0 && !start_store))
        else $error("retirement active during reset");

endmodule

// File: hw/rob_core_top.sv
// rob core top level
// connects rename map, free list and reorder buffer
`timescale 1ns/1ps

module rob_core_top (
    input  logic                                      clock,
    input  logic                                      reset,
    input  rob_pkg::decoded_packet_t [rob_pkg::N-1:0] disp_packets,
    input  rob_pkg::width_cnt_t                       disp_count,
    output rob_pkg::width_cnt_t                       disp_accept,
    output rob_pkg::phys_reg_idx_t   [rob_pkg::N-1:0] disp_t,
    input  rob_pkg::cdb_packet_t     [rob_pkg::N-1:0] cdb,
    input  logic                                      dm_stalled,
    output rob_pkg::rob_packet_t     [rob_pkg::N-1:0] retiring,
    output rob_pkg::width_cnt_t                       num_retired,
    output logic                                      start_store
);
    import rob_pkg::*;

    width_cnt_t                 open_entries;
    width_cnt_t                 free_count;
    phys_reg_idx_t [N-1:0]      t_old;
    phys_reg_idx_t [N-1:0]      release_t;

    // retired old tags feed straight back to the free list
    for (genvar i = 0; i < N; i++) begin : g_release
        assign release_t[i] = retiring[i].t_old;
    end

    rename_map u_rename_map (
        .clock        (clock),
        .reset        (reset),
        .disp_packets (disp_packets),
        .disp_count   (disp_count),
        .open_entries (open_entries),
        .free_count   (free_count),
        .new_t        (disp_t),
        .num_accept   (disp_accept),
        .t_old        (t_old)
    );

    // alloc tags double as the exported dispatch tags
    free_list u_free_list (
        .clock         (clock),
        .reset         (reset),
        .alloc_count   (disp_accept),
        .alloc_t       (disp_t),
        .free_count    (free_count),
        .release_count (num_retired),
        .release_t     (release_t)
    );

    rob u_rob (
        .clock         (clock),
        .reset         (reset),
        .wr_data       (disp_packets),
        .t             (disp_t),
        .t_old         (t_old),
        .num_accept    (disp_accept),
        .cdb           (cdb),
        .dm_stalled    (dm_stalled),
        .retiring_data (retiring),
        .num_retired   (num_retired),
        .open_entries  (open_entries),
        .start_store   (start_store)
    );

endmodule

// File: hw/rob.sv
// reorder buffer, N wide circular queue
// marks completions from the cdb and retires finished entries in program order
`timescale 1ns/1ps

module rob (
    input  logic                                      clock,
    input  logic                                      reset,
    input  rob_pkg::decoded_packet_t [rob_pkg::N-1:0] wr_data,
    input  rob_pkg::phys_reg_idx_t   [rob_pkg::N-1:0] t,
    input  rob_pkg::phys_reg_idx_t   [rob_pkg::N-1:0] t_old,
    input  rob_pkg::width_cnt_t                       num_accept,
    input  rob_pkg::cdb_packet_t     [rob_pkg::N-1:0] cdb,
    input  logic                                      dm_stalled,
    output rob_pkg::rob_packet_t     [rob_pkg::N-1:0] retiring_data,
    output rob_pkg::width_cnt_t                       num_retired,
    output rob_pkg::width_cnt_t                       open_entries,
    output logic                                      start_store
);
    import rob_pkg::*;

    rob_idx_t                      head, next_head;
    rob_idx_t                      tail, next_tail;
    logic [ROB_CNT_W-1:0]          count, next_count;
    rob_packet_t [ROB_DEPTH-1:0]   entries, next_entries;
    logic                          halted, next_halted;

    // retire from head, oldest first
    always_comb begin
        rob_idx_t idx;
        logic     stop;

        retiring_data = '0;
        num_retired   = '0;
        start_store   = 1'b0;
        next_halted   = halted;
        stop          = halted;   // nothing leaves once a halt is gone

        for (int i = 0; i < N; i++) begin
            idx = rob_idx_t'(head + i);
            if (stop || !entries[idx].valid || !entries[idx].complete) begin
                stop = 1'b1;
            end else if (entries[idx].wr_mem && (dm_stalled || start_store)) begin
                // one store per cycle, none while memory is busy
                stop = 1'b1;
            end else begin
                retiring_data[i] = entries[idx];
                num_retired      = num_retired + width_cnt_t'(1);
                if (entries[idx].wr_mem) begin
                    start_store = 1'b1;
                end
                if (entries[idx].halt) begin
                    // halt retires, everything behind it waits forever
                    next_halted = 1'b1;
                    stop        = 1'b1;
                end
            end
        end
    end

    // space includes slots freed by this cycle's retirement
    always_comb begin
        int space;

        space = ROB_DEPTH - int'(count) + int'(num_retired);
        if (space > N) begin
            open_entries = width_cnt_t'(N);
        end else begin
            open_entries = width_cnt_t'(space);
        end
    end

    always_comb begin
        rob_idx_t idx;

        next_entries = entries;

        // retired slots leave the queue
        for (int i = 0; i < N; i++) begin
            idx = rob_idx_t'(head + i);
            if (i < int'(num_retired)) begin
                next_entries[idx].valid    = 1'b0;
                next_entries[idx].complete = 1'b0;
            end
        end

        // cdb tag match marks entries done and captures result
        for (int k = 0; k < ROB_DEPTH; k++) begin
            for (int j = 0; j < N; j++) begin
                if (next_entries[k].valid && cdb[j].valid && next_entries[k].t == cdb[j].t) begin
                    next_entries[k].complete = 1'b1;
                    next_entries[k].data     = cdb[j].data;
                end
            end
        end

        // accepted slots land at tail in order
        for (int j = 0; j < N; j++) begin
            idx = rob_idx_t'(tail + j);
            if (j < int'(num_accept)) begin
                next_entries[idx].valid        = 1'b1;
                next_entries[idx].complete     = 1'b0;
                next_entries[idx].pc           = wr_data[j].pc;
                next_entries[idx].dest_reg_idx = wr_data[j].dest_reg_idx;
                next_entries[idx].t            = t[j];
                next_entries[idx].t_old        = t_old[j];
                next_entries[idx].data         = '0;
                next_entries[idx].halt         = wr_data[j].halt;
                next_entries[idx].wr_mem       = wr_data[j].wr_mem;
            end
        end

        next_head  = rob_idx_t'(head + num_retired);
        next_tail  = rob_idx_t'(tail + num_accept);
        next_count = count - ROB_CNT_W'(num_retired) + ROB_CNT_W'(num_accept);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            halted <= 1'b0;
            // every slot starts empty
            for (int k = 0; k < ROB_DEPTH; k++) begin
                entries[k].valid    <= 1'b0;
                entries[k].complete <= 1'b0;
            end
        end else begin
            head    <= next_head;
            tail    <= next_tail;
            count   <= next_count;
            halted  <= next_halted;
            entries <= next_entries;
        end
    end

endmodule

// File: hw/rename_map.sv
// speculative rename map
// decides how many dispatch slots go in, gives their old tags, records new ones
`timescale 1ns/1ps

module rename_map (
    input  logic                                      clock,
    input  logic                                      reset,
    input  rob_pkg::decoded_packet_t [rob_pkg::N-1:0] disp_packets,
    input  rob_pkg::width_cnt_t                       disp_count,
    input  rob_pkg::width_cnt_t                       open_entries,
    input  rob_pkg::width_cnt_t                       free_count,
    input  rob_pkg::phys_reg_idx_t   [rob_pkg::N-1:0] new_t,
    output rob_pkg::width_cnt_t                       num_accept,
    output rob_pkg::phys_reg_idx_t   [rob_pkg::N-1:0] t_old
);
    import rob_pkg::*;

    phys_reg_idx_t [ARCH_REGS-1:0] map;

    // accept count is the tightest of the three limits
    always_comb begin
        num_accept = disp_count;
        if (open_entries < num_accept) begin
            num_accept = open_entries;
        end
        if (free_count < num_accept) begin
            num_accept = free_count;
        end
    end

    // old tag lookup with bypass from older slots in the bundle
    always_comb begin
        for (int i = 0; i < N; i++) begin
            t_old[i] = map[disp_packets[i].dest_reg_idx];
            // youngest earlier writer wins
            for (int j = 0; j < i; j++) begin
                if (disp_packets[j].dest_reg_idx == disp_packets[i].dest_reg_idx) begin
                    t_old[i] = new_t[j];
                end
            end
            // r0 is never renamed, its own tag is the one to free
            if (disp_packets[i].dest_reg_idx == '0) begin
                t_old[i] = new_t[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map r to r
            for (int r = 0; r < ARCH_REGS; r++) begin
                map[r] <= phys_reg_idx_t'(r);
            end
        end else begin
            // later slots overwrite earlier ones to the same register
            for (int j = 0; j < N; j++) begin
                if (j < int'(num_accept) && disp_packets[j].dest_reg_idx != '0) begin
                    map[disp_packets[j].dest_reg_idx] <= new_t[j];
                end
            end
        end
    end

endmodule

// File: hw/free_list.sv
// free list of physical register tags
// circular FIFO, up to N pops and N pushes per cycle
`timescale 1ns/1ps

module free_list (
    input  logic                                    clock,
    input  logic                                    reset,
    input  rob_pkg::width_cnt_t                     alloc_count,
    output rob_pkg::phys_reg_idx_t [rob_pkg::N-1:0] alloc_t,
    output rob_pkg::width_cnt_t                     free_count,
    input  rob_pkg::width_cnt_t                     release_count,
    input  rob_pkg::phys_reg_idx_t [rob_pkg::N-1:0] release_t
);
    import rob_pkg::*;

    phys_reg_idx_t [FREE_DEPTH-1:0] tags;
    logic [FL_IDX_W-1:0]            head;
    logic [FL_IDX_W-1:0]            tail;
    logic [FL_CNT_W-1:0]            count;

    // next N tags in FIFO order, valid up to free_count
    always_comb begin
        for (int i = 0; i < N; i++) begin
            alloc_t[i] = tags[FL_IDX_W'(head + i)];
        end
    end

    // saturate so it compares directly with other width counts
    assign free_count = (count > FL_CNT_W'(N)) ? width_cnt_t'(N) : width_cnt_t'(count);

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= FL_CNT_W'(FREE_DEPTH);
            // tags above the identity map start out free
            for (int i = 0; i < FREE_DEPTH; i++) begin
                tags[i] <= phys_reg_idx_t'(ARCH_REGS + i);
            end
        end else begin
            // returned tags go in behind the last free one
            for (int j = 0; j < N; j++) begin
                if (j < int'(release_count)) begin
                    tags[FL_IDX_W'(tail + j)] <= release_t[j];
                end
            end
            head  <= FL_IDX_W'(head + alloc_count);
            tail  <= FL_IDX_W'(tail + release_count);
            count <= count - FL_CNT_W'(alloc_count) + FL_CNT_W'(release_count);
        end
    end

endmodule

// File: hw/rob_pkg.sv
// rob core shared definitions
// sizes, meaningful widths and the packets passed between dispatch, rob and cdb
package rob_pkg;

    // dispatch and retire width
    localparam int N         = 2;
    localparam int ROB_DEPTH = 8;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    // free list holds every tag not covered by the reset map
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int FL_IDX_W   = $clog2(FREE_DEPTH);
    localparam int FL_CNT_W   = $clog2(FREE_DEPTH + 1);
    localparam int ROB_CNT_W  = $clog2(ROB_DEPTH + 1);

    typedef logic [4:0]  arch_reg_idx_t;
    typedef logic [5:0]  phys_reg_idx_t;
    typedef logic [2:0]  rob_idx_t;
    typedef logic [1:0]  width_cnt_t;   // 0 to N
    typedef logic [31:0] data_t;
    typedef logic [31:0] pc_t;

    // one decoded instruction from the front end
    typedef struct packed {
        pc_t           pc;
        arch_reg_idx_t dest_reg_idx;
        logic          halt;
        logic          wr_mem;
    } decoded_packet_t;

    // completion broadcast
    typedef struct packed {
        logic          valid;
        phys_reg_idx_t t;
        data_t         data;
    } cdb_packet_t;

    // one rob slot, also what leaves at retirement
    typedef struct packed {
        logic          valid;
        logic          complete;
        pc_t           pc;
        arch_reg_idx_t dest_reg_idx;
        phys_reg_idx_t t;
        phys_reg_idx_t t_old;   // freed when this entry retires
        data_t         data;
        logic          halt;
        logic          wr_mem;
    } rob_packet_t;

endpackage
